/* mat_mul_cfg_pkg.sv */
package mat_mul_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Array geometry
  ////////////////////////////////////////////////////////////////////////////

  // Edge of the systolic array, in elements
  localparam int mat_size = 4;

  // C keeps the low byte of each dot product, same width as A and B
  localparam int elem_w = 8;

  // One bank word carries a full row or column
  localparam int word_w = mat_size * elem_w;

  ////////////////////////////////////////////////////////////////////////////
  // Matrix bank
  ////////////////////////////////////////////////////////////////////////////

  // Regions A, B and C, mat_size words each
  localparam int bank_addr_w = 4;
  localparam int bank_words  = 3 * mat_size;

  // Last operand feed until the bottom-right cell has accumulated
  localparam int drain_cycles = 2 * mat_size - 1;

  typedef logic [elem_w-1:0] elem_t;
  typedef logic [word_w-1:0] word_t;

endpackage

/* mat_mul_map_pkg.sv */
package mat_mul_map_pkg;

  // Host byte address, word aligned
  localparam int axi_addr_w = 8;

  // Top two bits of the word address
  typedef enum logic [1:0] {
    region_a   = 2'd0,
    region_b   = 2'd1,
    region_c   = 2'd2,
    region_csr = 2'd3
  } region_e;

  // Register select inside region_csr
  typedef enum logic [3:0] {
    csr_control = 4'd0,
    csr_status  = 4'd1
  } csr_sel_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_e;

  // Byte address bits 7:2, read as a bank row or as a register select
  typedef union packed {
    struct packed {
      region_e    region;
      logic [3:0] row;
    } mem_view;
    struct packed {
      region_e  region;
      csr_sel_e sel;
    } csr_view;
  } host_addr_u;

endpackage

/* matrix_bank.sv */
`timescale 1ns/1ps

module matrix_bank #(
  parameter int depth = mat_mul_cfg_pkg::bank_words
) (
  input  logic                                   clk_mem,
  input  logic                                   reset,
  input  logic                                   we,
  input  logic [mat_mul_cfg_pkg::bank_addr_w-1:0] addr,
  input  mat_mul_cfg_pkg::word_t                 wdata,
  output mat_mul_cfg_pkg::word_t                 rdata
);
  import mat_mul_cfg_pkg::*;

  word_t mem [depth];

  always_ff @(posedge clk_mem) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Read port registered, held during a write
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      rdata <= '0;
    end else if (!we) begin
      rdata <= mem[addr];
    end
  end

endmodule

/* bank_arbiter.sv */
`timescale 1ns/1ps

module bank_arbiter (
  input  logic                                   clk_mem,
  input  logic                                   reset,
  input  logic                                   host_req,
  input  logic                                   host_we,
  input  logic [mat_mul_cfg_pkg::bank_addr_w-1:0] host_addr,
  input  mat_mul_cfg_pkg::word_t                 host_wdata,
  output logic                                   host_gnt,
  input  logic                                   seq_req,
  input  logic                                   seq_we,
  input  logic [mat_mul_cfg_pkg::bank_addr_w-1:0] seq_addr,
  input  mat_mul_cfg_pkg::word_t                 seq_wdata,
  output logic                                   bank_we,
  output logic [mat_mul_cfg_pkg::bank_addr_w-1:0] bank_addr,
  output mat_mul_cfg_pkg::word_t                 bank_wdata
);
  import mat_mul_cfg_pkg::*;

  logic [bank_addr_w-1:0] hold_addr;

  // Sequencer first, the host only gets an idle bank
  assign host_gnt = host_req && !seq_req;

  always_comb begin
    if (seq_req) begin
      bank_we    = seq_we;
      bank_addr  = seq_addr;
      bank_wdata = seq_wdata;
    end else begin
      bank_we    = host_gnt && host_we;
      bank_addr  = host_gnt ? host_addr : hold_addr;
      bank_wdata = host_wdata;
    end
  end

  // Idle bank re-reads the last word, so host read data stays put
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      hold_addr <= '0;
    end else begin
      hold_addr <= bank_addr;
    end
  end

endmodule

/* axi_lite_host_port.sv */
`timescale 1ns/1ps

module axi_lite_host_port (
  input  logic                                   clk_mem,
  input  logic                                   reset,
  input  logic [mat_mul_map_pkg::axi_addr_w-1:0]  awaddr,
  input  logic                                   awvalid,
  output logic                                   awready,
  input  mat_mul_cfg_pkg::word_t                 wdata,
  input  logic [mat_mul_cfg_pkg::word_w/8-1:0]    wstrb,
  input  logic                                   wvalid,
  output logic                                   wready,
  output mat_mul_map_pkg::resp_e                 bresp,
  output logic                                   bvalid,
  input  logic                                   bready,
  input  logic [mat_mul_map_pkg::axi_addr_w-1:0]  araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  output mat_mul_cfg_pkg::word_t                 rdata,
  output mat_mul_map_pkg::resp_e                 rresp,
  output logic                                   rvalid,
  input  logic                                   rready,
  output logic                                   host_req,
  output logic                                   host_we,
  output logic [mat_mul_cfg_pkg::bank_addr_w-1:0] host_addr,
  output mat_mul_cfg_pkg::word_t                 host_wdata,
  input  logic                                   host_gnt,
  input  mat_mul_cfg_pkg::word_t                 bank_rdata,
  output logic                                   start,
  input  logic                                   busy,
  input  logic                                   done_pulse
);
  import mat_mul_cfg_pkg::*;
  import mat_mul_map_pkg::*;

  localparam int row_w = $clog2(mat_size);

  host_addr_u aw_dec;
  host_addr_u ar_dec;
  logic       aw_bank_ok;
  logic       aw_csr_ok;
  logic       ar_bank_ok;
  logic       ar_csr_ok;
  logic       wr_pend;
  logic       rd_pend;
  logic       wr_go;
  logic       rd_go;
  logic       done_q;
  logic       rd_bank_q;
  word_t      rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  assign aw_dec = awaddr[axi_addr_w-1:2];
  assign ar_dec = araddr[axi_addr_w-1:2];

  // C is read-only from the host
  assign aw_bank_ok = aw_dec.mem_view.region inside {region_a, region_b}
                      && aw_dec.mem_view.row < mat_size;
  assign aw_csr_ok  = aw_dec.csr_view.region == region_csr
                      && aw_dec.csr_view.sel == csr_control;
  assign ar_bank_ok = ar_dec.mem_view.region != region_csr
                      && ar_dec.mem_view.row < mat_size;
  assign ar_csr_ok  = ar_dec.csr_view.region == region_csr
                      && ar_dec.csr_view.sel inside {csr_control, csr_status};

  ////////////////////////////////////////////////////////////////////////////
  // Handshake, one access in flight
  ////////////////////////////////////////////////////////////////////////////

  assign wr_pend = awvalid && wvalid && !bvalid && !rvalid;
  assign rd_pend = arvalid && !bvalid && !rvalid && !wr_pend;

  // Bank accesses wait for the grant, the rest go straight through
  assign wr_go = wr_pend && (!aw_bank_ok || host_gnt);
  assign rd_go = rd_pend && (!ar_bank_ok || host_gnt);

  assign awready = wr_go;
  assign wready  = wr_go;
  assign arready = rd_go;

  assign host_req   = (wr_pend && aw_bank_ok) || (rd_pend && ar_bank_ok);
  assign host_we    = wr_pend;
  assign host_wdata = wdata;
  assign host_addr  = wr_pend ? {aw_dec.mem_view.region, aw_dec.mem_view.row[row_w-1:0]}
                              : {ar_dec.mem_view.region, ar_dec.mem_view.row[row_w-1:0]};

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      bvalid    <= 1'b0;
      rvalid    <= 1'b0;
      rd_bank_q <= 1'b0;
      start     <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      // Start while busy is dropped
      start <= wr_go && aw_csr_ok && wdata[0] && !busy;
      if (wr_go) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_go) begin
        rvalid    <= 1'b1;
        rd_bank_q <= ar_bank_ok;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      if (start) begin
        done_q <= 1'b0;
      end else if (done_pulse) begin
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_mem) begin
    if (wr_go) begin
      bresp <= (aw_bank_ok || aw_csr_ok) ? resp_okay : resp_slverr;
    end
    if (rd_go) begin
      rresp   <= (ar_bank_ok || ar_csr_ok) ? resp_okay : resp_slverr;
      rdata_q <= '0;
      if (ar_csr_ok && ar_dec.csr_view.sel == csr_status) begin
        rdata_q <= word_t'({done_q, busy});
      end
    end
  end

  // Bank word arrives with rvalid
  assign rdata = rd_bank_q ? bank_rdata : rdata_q;

endmodule

/* mac_cell.sv */
`timescale 1ns/1ps

module mac_cell (
  input  logic                   clk_mem,
  input  logic                   reset,
  input  logic                   clear,
  input  logic                   valid_in,
  input  mat_mul_cfg_pkg::elem_t a_in,
  input  mat_mul_cfg_pkg::elem_t b_in,
  output logic                   valid_out,
  output mat_mul_cfg_pkg::elem_t a_out,
  output mat_mul_cfg_pkg::elem_t b_out,
  output mat_mul_cfg_pkg::elem_t acc
);

  // Sum wraps at the element width
  always_ff @(posedge clk_mem) begin
    if (reset || clear) begin
      acc <= '0;
    end else if (valid_in) begin
      acc <= acc + a_in * b_in;
    end
  end

  // A moves east, B moves south
  always_ff @(posedge clk_mem) begin
    a_out <= a_in;
    b_out <= b_in;
  end

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

endmodule

/* systolic_array.sv */
`timescale 1ns/1ps

module systolic_array (
  input  logic                                         clk_mem,
  input  logic                                         reset,
  input  logic                                         clear,
  input  logic                                         feed_valid,
  input  mat_mul_cfg_pkg::word_t                       a_col,
  input  mat_mul_cfg_pkg::word_t                       b_row,
  input  logic [$clog2(mat_mul_cfg_pkg::mat_size)-1:0] row_sel,
  output mat_mul_cfg_pkg::word_t                       c_row
);
  import mat_mul_cfg_pkg::*;

  // Stage d holds the input word delayed d+1 cycles
  word_t               a_dly [mat_size-1];
  word_t               b_dly [mat_size-1];
  logic [mat_size-2:0] v_dly;

  // Grid links, the extra column and row fall off the edge
  wire elem_t a_e [mat_size][mat_size+1];
  wire elem_t b_s [mat_size+1][mat_size];
  wire        v_e [mat_size][mat_size+1];
  wire elem_t acc [mat_size][mat_size];

  ////////////////////////////////////////////////////////////////////////////
  // Input skew, row i and column j late by i and j cycles
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      v_dly <= '0;
    end else begin
      v_dly <= {v_dly[mat_size-3:0], feed_valid};
    end
  end

  always_ff @(posedge clk_mem) begin
    a_dly[0] <= a_col;
    b_dly[0] <= b_row;
    for (int d = 1; d < mat_size - 1; d++) begin
      a_dly[d] <= a_dly[d-1];
      b_dly[d] <= b_dly[d-1];
    end
  end

  for (genvar i = 0; i < mat_size; i++) begin : g_edge
    if (i == 0) begin : g_direct
      assign a_e[0][0] = a_col[elem_w-1:0];
      assign b_s[0][0] = b_row[elem_w-1:0];
      assign v_e[0][0] = feed_valid;
    end else begin : g_skewed
      assign a_e[i][0] = a_dly[i-1][i*elem_w +: elem_w];
      assign b_s[0][i] = b_dly[i-1][i*elem_w +: elem_w];
      assign v_e[i][0] = v_dly[i-1];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Cell grid
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < mat_size; i++) begin : g_row
    for (genvar j = 0; j < mat_size; j++) begin : g_col
      mac_cell mac_cell_i (
        .clk_mem   (clk_mem),
        .reset     (reset),
        .clear     (clear),
        .valid_in  (v_e[i][j]),
        .a_in      (a_e[i][j]),
        .b_in      (b_s[i][j]),
        .valid_out (v_e[i][j+1]),
        .a_out     (a_e[i][j+1]),
        .b_out     (b_s[i+1][j]),
        .acc       (acc[i][j])
      );
    end
  end

  // Selected C row
  always_comb begin
    for (int j = 0; j < mat_size; j++) begin
      c_row[j*elem_w +: elem_w] = acc[row_sel][j];
    end
  end

endmodule

/* mat_mul_sequencer.sv */
`timescale 1ns/1ps

module mat_mul_sequencer (
  input  logic                                         clk_mem,
  input  logic                                         reset,
  input  logic                                         start,
  output logic                                         busy,
  output logic                                         done_pulse,
  output logic                                         seq_req,
  output logic                                         seq_we,
  output logic [mat_mul_cfg_pkg::bank_addr_w-1:0]       seq_addr,
  output mat_mul_cfg_pkg::word_t                       seq_wdata,
  input  mat_mul_cfg_pkg::word_t                       bank_rdata,
  output logic                                         clear,
  output logic                                         feed_valid,
  output mat_mul_cfg_pkg::word_t                       a_col,
  output mat_mul_cfg_pkg::word_t                       b_row,
  output logic [$clog2(mat_mul_cfg_pkg::mat_size)-1:0] row_sel,
  input  mat_mul_cfg_pkg::word_t                       c_row
);
  import mat_mul_cfg_pkg::*;
  import mat_mul_map_pkg::*;

  localparam int step_w  = $clog2(2 * mat_size);
  localparam int drain_w = $clog2(drain_cycles);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_fetch = 2'd1;
  localparam logic [1:0] st_drain = 2'd2;
  localparam logic [1:0] st_write = 2'd3;

  logic [1:0]         state;
  logic [step_w-1:0]  step;
  logic [drain_w-1:0] drain_cnt;
  logic               rd_a_q;
  logic               rd_b_q;
  word_t              a_hold;

  ////////////////////////////////////////////////////////////////////////////
  // Phase FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      state     <= st_idle;
      step      <= '0;
      drain_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_fetch;
            step  <= '0;
          end
        end
        // Even steps read A column k, odd steps B row k
        st_fetch: begin
          step <= step + 1'b1;
          if (step == step_w'(2 * mat_size - 1)) begin
            state     <= st_drain;
            drain_cnt <= '0;
          end
        end
        st_drain: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == drain_w'(drain_cycles - 1)) begin
            state <= st_write;
            step  <= '0;
          end
        end
        default: begin
          step <= step + 1'b1;
          if (step == step_w'(mat_size - 1)) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      clear      <= 1'b0;
      rd_a_q     <= 1'b0;
      rd_b_q     <= 1'b0;
      done_pulse <= 1'b0;
    end else begin
      clear      <= state == st_idle && start;
      rd_a_q     <= state == st_fetch && !step[0];
      rd_b_q     <= state == st_fetch && step[0];
      done_pulse <= state == st_write && step == step_w'(mat_size - 1);
    end
  end

  // A word waits one cycle for its B partner
  always_ff @(posedge clk_mem) begin
    if (rd_a_q) begin
      a_hold <= bank_rdata;
    end
  end

  // Bank stays claimed through the drain gap
  assign busy    = state != st_idle;
  assign seq_req = busy;
  assign seq_we  = state == st_write;
  assign row_sel = step[$clog2(mat_size)-1:0];

  assign seq_addr = (state == st_write) ? {region_c, row_sel}
                                        : {step[0] ? region_b : region_a, step[step_w-1:1]};
  assign seq_wdata = c_row;

  assign feed_valid = rd_b_q;
  assign a_col      = a_hold;
  assign b_row      = bank_rdata;

endmodule

/* mat_mul_top.sv */
`timescale 1ns/1ps

module mat_mul_top (
  input  logic                                  clk_mem,
  input  logic                                  reset,
  input  logic [mat_mul_map_pkg::axi_addr_w-1:0] awaddr,
  input  logic                                  awvalid,
  output logic                                  awready,
  input  mat_mul_cfg_pkg::word_t                wdata,
  input  logic [mat_mul_cfg_pkg::word_w/8-1:0]   wstrb,
  input  logic                                  wvalid,
  output logic                                  wready,
  output mat_mul_map_pkg::resp_e                bresp,
  output logic                                  bvalid,
  input  logic                                  bready,
  input  logic [mat_mul_map_pkg::axi_addr_w-1:0] araddr,
  input  logic                                  arvalid,
  output logic                                  arready,
  output mat_mul_cfg_pkg::word_t                rdata,
  output mat_mul_map_pkg::resp_e                rresp,
  output logic                                  rvalid,
  input  logic                                  rready
);
  import mat_mul_cfg_pkg::*;

  // Host side of the bank
  logic                   host_req;
  logic                   host_we;
  logic [bank_addr_w-1:0] host_addr;
  word_t                  host_wdata;
  logic                   host_gnt;

  // Sequencer side of the bank
  logic                   seq_req;
  logic                   seq_we;
  logic [bank_addr_w-1:0] seq_addr;
  word_t                  seq_wdata;

  logic                   bank_we;
  logic [bank_addr_w-1:0] bank_addr;
  word_t                  bank_wdata;
  word_t                  bank_rdata;

  // Control and array feed
  logic                        start;
  logic                        busy;
  logic                        done_pulse;
  logic                        clear;
  logic                        feed_valid;
  word_t                       a_col;
  word_t                       b_row;
  logic [$clog2(mat_size)-1:0] row_sel;
  word_t                       c_row;

  axi_lite_host_port host_port_i (.*);

  bank_arbiter bank_arbiter_i (.*);

  matrix_bank #(
    .depth (bank_words)
  ) matrix_bank_i (
    .clk_mem (clk_mem),
    .reset   (reset),
    .we      (bank_we),
    .addr    (bank_addr),
    .wdata   (bank_wdata),
    .rdata   (bank_rdata)
  );

  mat_mul_sequencer sequencer_i (.*);

  systolic_array systolic_array_i (.*);

endmodule

/* tb_mat_mul_sva.sv */
`timescale 1ns/1ps

module tb_mat_mul_sva (
  input logic                                    clk_mem,
  input logic                                    reset,
  input logic                                    bvalid,
  input logic                                    bready,
  input logic                                    rvalid,
  input logic                                    rready,
  input mat_mul_cfg_pkg::word_t                  rdata,
  input logic                                    host_req,
  input logic                                    host_gnt,
  input logic [mat_mul_cfg_pkg::bank_addr_w-1:0] host_addr
);

  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite responses wait for the master
  ////////////////////////////////////////////////////////////////////////////

  bvalid_hold: assert property (@(posedge clk_mem) disable iff (reset)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge clk_mem) disable iff (reset)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  rdata_stable: assert property (@(posedge clk_mem) disable iff (reset)
    rvalid && !rready |=> $stable(rdata))
    else $error("rdata changed while rvalid waited");

  // Stalled host request keeps its address until the grant
  host_req_hold: assert property (@(posedge clk_mem) disable iff (reset)
    host_req && !host_gnt |=> host_req && $stable(host_addr))
    else $error("host request changed before its grant");

endmodule

bind axi_lite_host_port tb_mat_mul_sva axi_sva_i (
  .clk_mem   (clk_mem),
  .reset     (reset),
  .bvalid    (bvalid),
  .bready    (bready),
  .rvalid    (rvalid),
  .rready    (rready),
  .rdata     (rdata),
  .host_req  (1'b0),
  .host_gnt  (1'b0),
  .host_addr ('0)
);

bind bank_arbiter tb_mat_mul_sva arb_sva_i (
  .clk_mem   (clk_mem),
  .reset     (reset),
  .bvalid    (1'b0),
  .bready    (1'b0),
  .rvalid    (1'b0),
  .rready    (1'b0),
  .rdata     ('0),
  .host_req  (host_req),
  .host_gnt  (host_gnt),
  .host_addr (host_addr)
);

/* tb_mat_mul.sv */
`timescale 1ns/1ps

module tb_mat_mul;
  import mat_mul_cfg_pkg::*;
  import mat_mul_map_pkg::*;

  // Run limit from the number of tests and the longest one
  localparam int num_tests      = 5;
  localparam int access_cycles  = 6;
  localparam int max_accesses   = 32;
  localparam int compute_cycles = 3 * mat_size + drain_cycles + 4;
  localparam int test_cycles    = max_accesses * access_cycles + compute_cycles;
  localparam int timeout_cycles = num_tests * test_cycles;

  logic                  clk_mem;
  logic                  reset;
  logic [axi_addr_w-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  word_t                 wdata;
  logic [word_w/8-1:0]   wstrb;
  logic                  wvalid;
  logic                  wready;
  resp_e                 bresp;
  logic                  bvalid;
  logic                  bready;
  logic [axi_addr_w-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  word_t                 rdata;
  resp_e                 rresp;
  logic                  rvalid;
  logic                  rready;

  // Reference copies of the matrices in the bank
  elem_t a_m [mat_size][mat_size];
  elem_t b_m [mat_size][mat_size];
  word_t c_exp [$];

  int errors;
  int checks;
  int cycle_cnt;
  int wait_cycles;

  mat_mul_top mat_mul_top_i (.*);

  always #10 clk_mem = ~clk_mem;

  always @(posedge clk_mem) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and data helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [axi_addr_w-1:0] mem_addr(region_e region, int row);
    return {region, 4'(row), 2'b00};
  endfunction

  function automatic logic [axi_addr_w-1:0] reg_addr(logic [3:0] sel);
    return {region_csr, sel, 2'b00};
  endfunction

  // Bank word k of region A holds column k
  function automatic word_t a_column(int k);
    word_t w;
    for (int i = 0; i < mat_size; i++) begin
      w[i*elem_w +: elem_w] = a_m[i][k];
    end
    return w;
  endfunction

  function automatic word_t b_row_word(int k);
    word_t w;
    for (int j = 0; j < mat_size; j++) begin
      w[j*elem_w +: elem_w] = b_m[k][j];
    end
    return w;
  endfunction

  task automatic fill_random(input bit a_identity);
    for (int i = 0; i < mat_size; i++) begin
      for (int j = 0; j < mat_size; j++) begin
        a_m[i][j] = a_identity ? elem_t'(i == j) : elem_t'($urandom);
        b_m[i][j] = elem_t'($urandom);
      end
    end
  endtask

  // Dot products kept modulo 256
  task automatic model_product();
    int    sum;
    word_t w;
    c_exp.delete();
    for (int i = 0; i < mat_size; i++) begin
      for (int j = 0; j < mat_size; j++) begin
        sum = 0;
        for (int k = 0; k < mat_size; k++) begin
          sum += a_m[i][k] * b_m[k][j];
        end
        w[j*elem_w +: elem_w] = elem_t'(sum % 256);
      end
      c_exp.push_back(w);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input word_t got, input word_t exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input resp_e got, input resp_e exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_status(input logic [1:0] got, input logic [1:0] exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite master
  ////////////////////////////////////////////////////////////////////////////

  task automatic axi_write(input logic [axi_addr_w-1:0] addr, input word_t data,
                           output resp_e resp);
    @(negedge clk_mem);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    while (!awready) begin
      @(negedge clk_mem);
      #1;
    end
    // Address and data are taken in the same cycle
    checks++;
    if (wready !== 1'b1) begin
      errors++;
      $display("[ERROR] %0t wready: got %b, expected 1", $time, wready);
    end
    @(negedge clk_mem);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      @(negedge clk_mem);
    end
    // Response is left waiting a little before bready
    repeat (1 + $urandom % 3) @(negedge clk_mem);
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk_mem);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [axi_addr_w-1:0] addr, output word_t data,
                          output resp_e resp);
    @(negedge clk_mem);
    araddr      = addr;
    arvalid     = 1'b1;
    wait_cycles = 0;
    #1;
    while (!arready) begin
      @(negedge clk_mem);
      #1;
      wait_cycles++;
    end
    @(negedge clk_mem);
    arvalid = 1'b0;
    while (!rvalid) begin
      @(negedge clk_mem);
    end
    // Read data has to wait for rready as well
    repeat (1 + $urandom % 3) @(negedge clk_mem);
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk_mem);
    rready = 1'b0;
  endtask

  task automatic load_matrices();
    resp_e resp;
    for (int k = 0; k < mat_size; k++) begin
      axi_write(mem_addr(region_a, k), a_column(k), resp);
      check_resp(resp, resp_okay, "bresp (A load)");
      axi_write(mem_addr(region_b, k), b_row_word(k), resp);
      check_resp(resp, resp_okay, "bresp (B load)");
    end
  endtask

  task automatic start_product();
    resp_e resp;
    axi_write(reg_addr(csr_control), word_t'(1), resp);
    check_resp(resp, resp_okay, "bresp (control)");
  endtask

  // Poll status until done and expect busy low by then
  task automatic wait_done();
    word_t data;
    resp_e resp;
    data = '0;
    while (!data[1]) begin
      axi_read(reg_addr(csr_status), data, resp);
      check_resp(resp, resp_okay, "rresp (status)");
    end
    check_status(data[1:0], 2'b10, "status {done, busy}");
  endtask

  task automatic check_c_rows();
    word_t data;
    resp_e resp;
    for (int i = 0; i < mat_size; i++) begin
      axi_read(mem_addr(region_c, i), data, resp);
      check_resp(resp, resp_okay, "rresp (C)");
      check_word(data, c_exp[i], $sformatf("rdata (C row %0d)", i));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_bank_readback();
    word_t words [2*mat_size];
    word_t data;
    resp_e resp;
    for (int w = 0; w < 2 * mat_size; w++) begin
      words[w] = $urandom;
      axi_write(mem_addr(region_e'(w / mat_size), w % mat_size), words[w], resp);
      check_resp(resp, resp_okay, "bresp (A/B write)");
    end
    for (int w = 0; w < 2 * mat_size; w++) begin
      axi_read(mem_addr(region_e'(w / mat_size), w % mat_size), data, resp);
      check_resp(resp, resp_okay, "rresp (A/B read)");
      check_word(data, words[w], $sformatf("rdata (bank word %0d)", w));
    end
  endtask

  // Identity times B gives B
  task automatic test_identity();
    fill_random(1'b1);
    load_matrices();
    start_product();
    wait_done();
    c_exp.delete();
    for (int i = 0; i < mat_size; i++) begin
      c_exp.push_back(b_row_word(i));
    end
    check_c_rows();
  endtask

  task automatic test_random_product();
    fill_random(1'b0);
    load_matrices();
    model_product();
    start_product();
    wait_done();
    check_c_rows();
  endtask

  task automatic test_second_product();
    word_t data;
    resp_e resp;
    fill_random(1'b0);
    load_matrices();
    model_product();
    start_product();
    axi_read(reg_addr(csr_status), data, resp);
    check_status(data[1:0], 2'b01, "status {done, busy} after start");
    wait_done();
    check_c_rows();
  endtask

  task automatic test_errors_and_stall();
    word_t data;
    word_t junk;
    resp_e resp;
    junk = $urandom;
    axi_write(mem_addr(region_c, 0), junk, resp);
    check_resp(resp, resp_slverr, "bresp (C write)");
    axi_read(mem_addr(region_c, 0), data, resp);
    check_word(data, c_exp[0], "rdata (C row 0 after C write)");
    axi_write(reg_addr(4'd2), junk, resp);
    check_resp(resp, resp_slverr, "bresp (unmapped register)");
    axi_read(reg_addr(4'd2), data, resp);
    check_resp(resp, resp_slverr, "rresp (unmapped register)");
    axi_write(mem_addr(region_a, mat_size), junk, resp);
    check_resp(resp, resp_slverr, "bresp (A row 4)");
    axi_read(mem_addr(region_b, mat_size), data, resp);
    check_resp(resp, resp_slverr, "rresp (B row 4)");
    axi_read(mem_addr(region_a, 0), data, resp);
    check_word(data, a_column(0), "rdata (A word 0 after row 4 write)");
    // New product with a C read while the sequencer owns the bank
    fill_random(1'b0);
    load_matrices();
    model_product();
    start_product();
    axi_read(mem_addr(region_c, mat_size - 1), data, resp);
    if (wait_cycles == 0) begin
      errors++;
      $display("A C read during the computation was accepted without waiting");
    end
    check_resp(resp, resp_okay, "rresp (C read while busy)");
    check_word(data, c_exp[mat_size-1], "rdata (C row 3 read while busy)");
    axi_read(reg_addr(csr_status), data, resp);
    check_status(data[1:0], 2'b10, "status {done, busy} after stalled read");
  endtask

  initial begin
    void'($urandom(32'hff93_e824));
    clk_mem   = 1'b0;
    reset     = 1'b1;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '1;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    errors    = 0;
    checks    = 0;
    cycle_cnt = 0;
    repeat (3) @(negedge clk_mem);
    reset = 1'b0;
    test_bank_readback();
    test_identity();
    test_random_product();
    test_second_product();
    test_errors_and_stall();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
mat_mul_cfg_pkg.sv
mat_mul_map_pkg.sv
matrix_bank.sv
bank_arbiter.sv
axi_lite_host_port.sv
mac_cell.sv
systolic_array.sv
mat_mul_sequencer.sv
mat_mul_top.sv
tb_mat_mul_sva.sv
tb_mat_mul.sv

/* Bender.yml */
package:
  name: mat_mul

sources:
  - mat_mul_cfg_pkg.sv
  - mat_mul_map_pkg.sv
  - matrix_bank.sv
  - bank_arbiter.sv
  - axi_lite_host_port.sv
  - mac_cell.sv
  - systolic_array.sv
  - mat_mul_sequencer.sv
  - mat_mul_top.sv
  - target: test
    files:
      - tb_mat_mul_sva.sv
      - tb_mat_mul.sv
